// File: mul_cases.txt
// op (0 mul, 1 mulh, 2 mulhsu, 3 mulhu, 4 mulw), operand a, operand b, expected
// all fields in hex, results are the 64-bit value written to rd
0 0000000000000003 0000000000000005 000000000000000f
0 ffffffffffffffff 0000000000000002 fffffffffffffffe
0 0000000000000000 0000000000000123 0000000000000000
0 0000000100000000 0000000100000000 0000000000000000
0 123456789abcdef0 0000000000000010 23456789abcdef00
1 ffffffffffffffff ffffffffffffffff 0000000000000000
1 ffffffffffffffff 0000000000000002 ffffffffffffffff
1 8000000000000000 8000000000000000 4000000000000000
1 0000000100000000 0000000100000000 0000000000000001
2 ffffffffffffffff ffffffffffffffff ffffffffffffffff
2 0000000000000002 ffffffffffffffff 0000000000000001
3 ffffffffffffffff ffffffffffffffff fffffffffffffffe
3 8000000000000000 0000000000000002 0000000000000001
3 123456789abcdef0 0000000000000010 0000000000000001
4 0000000100000003 0000000200000005 000000000000000f
4 00000000ffffffff 0000000000000002 fffffffffffffffe
4 0000000080000000 0000000000000002 0000000000000000
4 0000000040000000 0000000000000002 ffffffff80000000

// File: flist.f
npc_pkg.sv
gpr_file.sv
booth_multiplier.sv
mul_issue_ctrl.sv
npc_mul_top.sv
tb_npc_mul.sv

// File: tb_npc_mul.sv
`timescale 1ns/100ps
`default_nettype none

module tb_npc_mul import npc_pkg::*; ();

	// **************************************************
	// run length and limits
	// **************************************************

	localparam int N_RANDOM = 200;
	// upper bound on lines taken from the case file
	localparam int N_DIRECTED_MAX = 64;
	// busy-drop, flush and x0 commands
	localparam int N_EXTRA = 8;
	localparam int CYCLES_PER_CMD = 60;
	localparam int WATCHDOG_CYCLES =
		(N_DIRECTED_MAX + N_RANDOM + N_EXTRA) * CYCLES_PER_CMD + 1000;
	// per-command wait for done
	localparam int DONE_LIMIT = 100;

	logic      clk;
	logic      rst;
	logic      cmd_valid;
	mul_cmd_t  cmd;
	logic      flush;
	logic      busy;
	logic      done;
	wb_t       done_wb;
	logic      load_en;
	reg_addr_t load_addr;
	word_t     load_data;
	reg_addr_t dbg_addr;
	word_t     dbg_data;

	// galois lfsr state
	logic [31:0] lfsr = 32'd3;

	npc_mul_top uut (
		.clk       (clk),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.flush     (flush),
		.busy      (busy),
		.done      (done),
		.done_wb   (done_wb),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.dbg_addr  (dbg_addr),
		.dbg_data  (dbg_data)
	);

	// 20 ns clock
	always #10 clk = ~clk;

	// **************************************************
	// helpers
	// **************************************************

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// one lfsr step per bit taken
	task automatic draw_bits(input int n, output word_t v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[XLEN-2:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// nonzero register index distinct from x and y
	task automatic pick_reg(input reg_addr_t x, input reg_addr_t y, output reg_addr_t r);
		word_t v;
		r = '0;
		while ((r == '0) || (r == x) || (r == y)) begin
			draw_bits(5, v);
			r = v[4:0];
		end
	endtask

	// reference product from the op definitions in 128-bit arithmetic
	function automatic word_t product_half(input mul_op_t op, input word_t a, input word_t b);
		logic [2*XLEN-1:0] ax;
		logic [2*XLEN-1:0] bx;
		logic [2*XLEN-1:0] p;
		logic [31:0]       pw;
		ax = {{XLEN{1'b0}}, a};
		bx = {{XLEN{1'b0}}, b};
		if ((op == OP_MUL) || (op == OP_MULH) || (op == OP_MULHSU)) begin
			ax = {{XLEN{a[XLEN-1]}}, a};
		end
		if ((op == OP_MUL) || (op == OP_MULH)) begin
			bx = {{XLEN{b[XLEN-1]}}, b};
		end
		p = ax * bx;
		// low 32 bits do not depend on signedness
		pw = a[31:0] * b[31:0];
		case (op)
			OP_MULH, OP_MULHSU, OP_MULHU: return p[2*XLEN-1:XLEN];
			OP_MULW: return {{32{pw[31]}}, pw};
			default: return p[XLEN-1:0];
		endcase
	endfunction

	// **************************************************
	// bus tasks
	// **************************************************

	task automatic load_reg(input reg_addr_t addr, input word_t data);
		@(posedge clk);
		load_en <= 1'b1;
		load_addr <= addr;
		load_data <= data;
		@(posedge clk);
		load_en <= 1'b0;
	endtask

	// debug port sampled mid-cycle
	task automatic read_reg(input reg_addr_t addr, output word_t data);
		@(posedge clk);
		dbg_addr <= addr;
		@(negedge clk);
		data = dbg_data;
	endtask

	task automatic issue_cmd(input mul_op_t op, input reg_addr_t rd,
		input reg_addr_t rs1, input reg_addr_t rs2);
		@(posedge clk);
		cmd_valid <= 1'b1;
		cmd <= '{op: op, rd: rd, rs1: rs1, rs2: rs2};
		@(posedge clk);
		cmd_valid <= 1'b0;
	endtask

	// returns in the done cycle with done_wb captured
	task automatic wait_done(output wb_t got);
		int n;
		n = 0;
		@(negedge clk);
		while (!done) begin
			n++;
			assert (n < DONE_LIMIT)
			else abort_run("done never came for an issued command");
			@(negedge clk);
		end
		got = done_wb;
	endtask

	task automatic expect_no_done(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			assert (!done)
			else abort_run($sformatf("Mismatch at %0t: done pulsed unexpectedly", $time));
		end
	endtask

	// load, issue, check write-back and register contents
	task automatic run_and_check(input mul_op_t op, input reg_addr_t rd,
		input reg_addr_t rs1, input reg_addr_t rs2, input word_t a, input word_t b,
		input word_t exp);
		wb_t   got;
		word_t rd_val;
		load_reg(rs1, a);
		load_reg(rs2, b);
		issue_cmd(op, rd, rs1, rs2);
		wait_done(got);
		assert (got.rd == rd)
		else abort_run($sformatf("Mismatch at %0t: done_wb.rd %0d, expected %0d",
			$time, got.rd, rd));
		assert (got.data == exp)
		else abort_run($sformatf("Mismatch at %0t: op %0d a %h b %h gave %h, expected %h",
			$time, op, a, b, got.data, exp));
		read_reg(rd, rd_val);
		assert (rd_val == exp)
		else abort_run($sformatf("Mismatch at %0t: x%0d holds %h, expected %h",
			$time, rd, rd_val, exp));
	endtask

	// **************************************************
	// watchdog
	// **************************************************

	initial begin
		#(WATCHDOG_CYCLES * 20);
		abort_run("watchdog expired, the run did not finish in time");
	end

	// **************************************************
	// main sequence
	// **************************************************

	initial begin
		int               fd;
		int               code;
		int               n_cases;
		logic [8*200-1:0] line;
		logic [31:0]      f_op;
		word_t            f_a;
		word_t            f_b;
		word_t            f_e;
		word_t            ra;
		word_t            rb;
		word_t            v;
		reg_addr_t        r1;
		reg_addr_t        r2;
		reg_addr_t        rd;
		mul_op_t          op;
		wb_t              got;

		clk = 1'b0;
		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		flush = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		dbg_addr = '0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		// loads read back and x0 stays zero
		load_reg(5'd5, 64'h0123_4567_89ab_cdef);
		read_reg(5'd5, v);
		assert (v == 64'h0123_4567_89ab_cdef)
		else abort_run($sformatf("Mismatch at %0t: load readback %h", $time, v));
		load_reg(5'd0, 64'hdead_beef_dead_beef);
		read_reg(5'd0, v);
		assert (v == '0)
		else abort_run($sformatf("Mismatch at %0t: x0 reads %h", $time, v));

		// directed cases from file
		fd = $fopen("mul_cases.txt", "r");
		assert (fd != 0)
		else abort_run("could not open mul_cases.txt");
		n_cases = 0;
		while (!$feof(fd)) begin
			line = '0;
			code = $fgets(line, fd);
			if (code > 0) begin
				// comment lines parse to zero fields
				code = $sscanf(line, "%h %h %h %h", f_op, f_a, f_b, f_e);
				if ((code == 4) && (n_cases < N_DIRECTED_MAX)) begin
					run_and_check(mul_op_t'(f_op[2:0]), 5'd3, 5'd1, 5'd2, f_a, f_b, f_e);
					n_cases++;
				end
			end
		end
		$fclose(fd);
		assert (n_cases > 0)
		else abort_run("no cases were read from mul_cases.txt");

		// random operands with the ops in rotation
		for (int i = 0; i < N_RANDOM; i++) begin
			op = mul_op_t'(i % 5);
			draw_bits(XLEN, ra);
			draw_bits(XLEN, rb);
			pick_reg('0, '0, r1);
			pick_reg(r1, '0, r2);
			pick_reg(r1, r2, rd);
			run_and_check(op, rd, r1, r2, ra, rb, product_half(op, ra, rb));
		end

		// second command while busy is dropped
		load_reg(5'd11, 64'h1111_2222_3333_4444);
		load_reg(5'd6, 64'd7);
		load_reg(5'd7, 64'd9);
		issue_cmd(OP_MUL, 5'd10, 5'd6, 5'd7);
		@(negedge clk);
		assert (busy)
		else abort_run($sformatf("Mismatch at %0t: busy low after a command was accepted",
			$time));
		issue_cmd(OP_MULHU, 5'd11, 5'd6, 5'd7);
		wait_done(got);
		assert ((got.rd == 5'd10) && (got.data == 64'd63))
		else abort_run($sformatf("Mismatch at %0t: busy-drop wb rd %0d data %h",
			$time, got.rd, got.data));
		expect_no_done(int'(STEPS_D) + 8);
		read_reg(5'd11, v);
		assert (v == 64'h1111_2222_3333_4444)
		else abort_run($sformatf("Mismatch at %0t: dropped command wrote x11 %h", $time, v));

		// flush partway through
		load_reg(5'd12, 64'h5555_aaaa_5555_aaaa);
		issue_cmd(OP_MULH, 5'd12, 5'd6, 5'd7);
		expect_no_done(10);
		@(posedge clk);
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		@(negedge clk);
		assert (!busy)
		else abort_run($sformatf("Mismatch at %0t: busy still high one cycle after flush",
			$time));
		expect_no_done(int'(STEPS_D) + 8);
		read_reg(5'd12, v);
		assert (v == 64'h5555_aaaa_5555_aaaa)
		else abort_run($sformatf("Mismatch at %0t: flushed command wrote x12 %h", $time, v));
		run_and_check(OP_MULW, 5'd12, 5'd6, 5'd7, 64'hffff_ffff, 64'd3,
			64'hffff_ffff_ffff_fffd);

		// rd = x0 still completes
		issue_cmd(OP_MUL, 5'd0, 5'd6, 5'd7);
		wait_done(got);
		assert ((got.rd == 5'd0) && (got.data == 64'h0000_0002_ffff_fffd))
		else abort_run($sformatf("Mismatch at %0t: x0 command wb rd %0d data %h",
			$time, got.rd, got.data));
		read_reg(5'd0, v);
		assert (v == '0)
		else abort_run($sformatf("Mismatch at %0t: x0 reads %h after write-back", $time, v));

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: npc_mul_top.sv
`timescale 1ns/100ps
`default_nettype none

module npc_mul_top import npc_pkg::*; (
	input  wire            clk,
	input  wire            rst,
	// command
	input  wire            cmd_valid,
	input  wire mul_cmd_t  cmd,
	input  wire            flush,
	output logic           busy,
	output logic           done,
	output wb_t            done_wb,
	// register load port
	input  wire            load_en,
	input  wire reg_addr_t load_addr,
	input  wire word_t     load_data,
	// debug read
	input  wire reg_addr_t dbg_addr,
	output word_t          dbg_data
);

	// register file reads
	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	word_t     rs1_data;
	word_t     rs2_data;

	// multiplier handshake
	logic     mul_start;
	logic     mul_kill;
	mul_req_t mul_req;
	logic     mul_done;
	mul_res_t mul_res;

	// write sources
	logic wb_en;
	wb_t  wb;
	logic wr_en;
	wb_t  wr;

	// **************************************************
	// write port merge
	// **************************************************

	// write-back wins over a colliding load
	assign wr_en = wb_en | load_en;
	assign wr = wb_en ? wb : wb_t'{rd: load_addr, data: load_data};

	// **************************************************
	// instances
	// **************************************************

	gpr_file u_gpr (
		.clk      (clk),
		.rs1_addr (rs1_addr),
		.rs1_data (rs1_data),
		.rs2_addr (rs2_addr),
		.rs2_data (rs2_data),
		.dbg_addr (dbg_addr),
		.dbg_data (dbg_data),
		.wr_en    (wr_en),
		.wr       (wr)
	);

	mul_issue_ctrl u_ctrl (
		.clk       (clk),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.flush     (flush),
		.busy      (busy),
		.done      (done),
		.done_wb   (done_wb),
		.rs1_addr  (rs1_addr),
		.rs2_addr  (rs2_addr),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.mul_start (mul_start),
		.mul_kill  (mul_kill),
		.mul_req   (mul_req),
		.mul_done  (mul_done),
		.mul_res   (mul_res),
		.wb_en     (wb_en),
		.wb        (wb)
	);

	booth_multiplier u_booth (
		.clk   (clk),
		.rst   (rst),
		.start (mul_start),
		.kill  (mul_kill),
		.req   (mul_req),
		.done  (mul_done),
		.res   (mul_res)
	);

endmodule

`default_nettype wire

// File: mul_issue_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module mul_issue_ctrl import npc_pkg::*; (
	input  wire           clk,
	input  wire           rst,
	// command side
	input  wire           cmd_valid,
	input  wire mul_cmd_t cmd,
	input  wire           flush,
	output logic          busy,
	output logic          done,
	output wb_t           done_wb,
	// register file reads
	output reg_addr_t     rs1_addr,
	output reg_addr_t     rs2_addr,
	input  wire word_t    rs1_data,
	input  wire word_t    rs2_data,
	// multiplier
	output logic          mul_start,
	output logic          mul_kill,
	output mul_req_t      mul_req,
	input  wire           mul_done,
	input  wire mul_res_t mul_res,
	// write-back
	output logic          wb_en,
	output wb_t           wb
);

	ctrl_state_t state;
	// set once the multiplier has been launched
	logic launched;

	// latched command and selected result
	mul_cmd_t cmd_q;
	word_t    result_q;
	word_t    result_sel;

	// **************************************************
	// outputs
	// **************************************************

	assign busy = (state != CTRL_IDLE);

	// operands read straight from the latched command
	assign rs1_addr = cmd_q.rs1;
	assign rs2_addr = cmd_q.rs2;

	// start only on the first run cycle
	assign mul_start = (state == CTRL_RUN) && !launched;
	assign mul_kill = flush;

	// flush in the wb cycle cancels the write
	assign wb_en = (state == CTRL_WB) && !flush;
	assign wb = '{rd: cmd_q.rd, data: result_q};
	assign done = wb_en;
	assign done_wb = wb;

	// op to sign and word flags
	always_comb begin
		mul_req.multiplicand = rs1_data;
		mul_req.multiplier = rs2_data;
		mul_req.word_mode = 1'b0;
		mul_req.sign_a = 1'b1;
		mul_req.sign_b = 1'b1;
		case (cmd_q.op)
			OP_MULHSU: mul_req.sign_b = 1'b0;
			OP_MULHU: begin
				mul_req.sign_a = 1'b0;
				mul_req.sign_b = 1'b0;
			end
			OP_MULW: mul_req.word_mode = 1'b1;
			default: ;
		endcase
	end

	// pick the product half
	always_comb begin
		case (cmd_q.op)
			OP_MULH, OP_MULHSU, OP_MULHU: result_sel = mul_res.hi;
			OP_MULW: result_sel = {{WLEN{mul_res.lo[WLEN-1]}}, mul_res.lo[WLEN-1:0]};
			default: result_sel = mul_res.lo;
		endcase
	end

	// **************************************************
	// FSM
	// **************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= CTRL_IDLE;
			launched <= 1'b0;
		end else if (flush) begin
			// drop whatever is in flight
			state <= CTRL_IDLE;
			launched <= 1'b0;
		end else begin
			case (state)
				CTRL_IDLE: begin
					launched <= 1'b0;
					// commands while busy never reach here
					if (cmd_valid) begin
						state <= CTRL_RUN;
					end
				end
				CTRL_RUN: begin
					launched <= 1'b1;
					if (mul_done) begin
						state <= CTRL_WB;
					end
				end
				CTRL_WB: begin
					launched <= 1'b0;
					state <= CTRL_IDLE;
				end
				default: state <= CTRL_IDLE;
			endcase
		end
	end

	// payload capture
	always_ff @(posedge clk) begin
		if ((state == CTRL_IDLE) && cmd_valid && !flush) begin
			cmd_q <= cmd;
		end
		if ((state == CTRL_RUN) && mul_done) begin
			result_q <= result_sel;
		end
	end

endmodule

`default_nettype wire

// File: booth_multiplier.sv
`timescale 1ns/100ps
`default_nettype none

module booth_multiplier import npc_pkg::*; (
	input  wire           clk,
	input  wire           rst,
	input  wire           start,
	input  wire           kill,
	input  wire mul_req_t req,
	output logic          done,
	output mul_res_t      res
);

	// control
	booth_state_t state;
	step_cnt_t    cnt;

	// datapath registers
	ext_t  x_q;
	prod_t prod_q;
	logic  word_q;

	// operand preparation
	word_t a_src;
	word_t b_src;
	ext_t  a_ext;
	ext_t  b_ext;

	// one recoding step
	acc_t  x_wide;
	acc_t  pp;
	acc_t  sum;
	prod_t prod_nxt;

	// final product, aligned per mode
	logic [2*XLEN-1:0] full_prod;

	logic accept;
	logic stepping;
	logic finish;

	assign accept = (state == BOOTH_IDLE) && start && !kill;
	assign stepping = (state == BOOTH_BUSY) && (cnt != '0);
	assign finish = (state == BOOTH_BUSY) && (cnt == '0) && !kill;

	// **************************************************
	// operand extension
	// **************************************************

	always_comb begin
		// word mode keeps the low half, sign-extended
		if (req.word_mode) begin
			a_src = {{WLEN{req.multiplicand[WLEN-1]}}, req.multiplicand[WLEN-1:0]};
			b_src = {{WLEN{req.multiplier[WLEN-1]}}, req.multiplier[WLEN-1:0]};
		end else begin
			a_src = req.multiplicand;
			b_src = req.multiplier;
		end
		// two guard bits, sign or zero per operand
		a_ext = {{2{req.sign_a & a_src[XLEN-1]}}, a_src};
		b_ext = {{2{req.sign_b & b_src[XLEN-1]}}, b_src};
	end

	// **************************************************
	// radix-4 booth step
	// **************************************************

	always_comb begin
		x_wide = {{(ACC_W-EXT_W){x_q[EXT_W-1]}}, x_q};
		// recode y[2i+1], y[2i], y[2i-1]
		case (prod_q[2:0])
			3'b001, 3'b010: pp = x_wide;
			3'b011:         pp = x_wide << 1;
			3'b100:         pp = -(x_wide << 1);
			3'b101, 3'b110: pp = -x_wide;
			default:        pp = '0;
		endcase
		// add into the upper part
		sum = prod_q[PROD_W-1 -: ACC_W] + pp;
		// arithmetic shift right by two
		prod_nxt = {{2{sum[ACC_W-1]}}, sum, prod_q[PROD_W-ACC_W-1:2]};
	end

	// product position depends on how many steps ran
	always_comb begin
		if (word_q) begin
			full_prod = {{(2*XLEN-(PROD_W-WORD_LSB)){prod_q[PROD_W-1]}},
				prod_q[PROD_W-1:WORD_LSB]};
		end else begin
			full_prod = prod_q[DWORD_LSB +: 2*XLEN];
		end
	end

	// **************************************************
	// control
	// **************************************************

	always_ff @(posedge clk) begin
		// single cycle pulse by default
		done <= 1'b0;
		if (rst) begin
			state <= BOOTH_IDLE;
			cnt <= '0;
		end else if (kill) begin
			// abandon the operation, no done for it
			state <= BOOTH_IDLE;
			cnt <= '0;
		end else begin
			case (state)
				BOOTH_IDLE: begin
					if (start) begin
						state <= BOOTH_BUSY;
						cnt <= req.word_mode ? STEPS_W : STEPS_D;
					end
				end
				BOOTH_BUSY: begin
					if (cnt != '0) begin
						cnt <= cnt - 1'b1;
					end else begin
						// all steps done, present result
						state <= BOOTH_IDLE;
						done <= 1'b1;
					end
				end
				default: state <= BOOTH_IDLE;
			endcase
		end
	end

	// **************************************************
	// datapath
	// **************************************************

	always_ff @(posedge clk) begin
		if (accept) begin
			x_q <= a_ext;
			// empty accumulator, multiplier, trailing zero
			prod_q <= {{ACC_W{1'b0}}, b_ext, 1'b0};
			word_q <= req.word_mode;
		end else if (stepping) begin
			prod_q <= prod_nxt;
		end
		// result captured together with done
		if (finish) begin
			res.hi <= full_prod[2*XLEN-1:XLEN];
			res.lo <= full_prod[XLEN-1:0];
		end
	end

endmodule

`default_nettype wire

// File: gpr_file.sv
`timescale 1ns/100ps
`default_nettype none

module gpr_file import npc_pkg::*; (
	input  wire       clk,
	// operand read ports
	input  wire       reg_addr_t rs1_addr,
	output word_t     rs1_data,
	input  wire       reg_addr_t rs2_addr,
	output word_t     rs2_data,
	// debug read port
	input  wire       reg_addr_t dbg_addr,
	output word_t     dbg_data,
	// single write port
	input  wire       wr_en,
	input  wire wb_t  wr
);

	// storage, x0 entry exists but is never read
	word_t regs [NREG];

	// **************************************************
	// write
	// **************************************************

	always_ff @(posedge clk) begin
		// writes to x0 are dropped
		if (wr_en && (wr.rd != '0)) begin
			regs[wr.rd] <= wr.data;
		end
	end

	// **************************************************
	// combinational reads
	// **************************************************

	// x0 forced to zero on every port
	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];
	assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];

endmodule

`default_nettype wire

// File: npc_pkg.sv
`default_nettype none

package npc_pkg;

	// **************************************************
	// basic widths
	// **************************************************

	localparam int XLEN = 64;
	localparam int NREG = 32;
	// half word used by the w-type ops
	localparam int WLEN = XLEN / 2;

	// data word and register index
	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// **************************************************
	// booth datapath widths
	// **************************************************

	// operands get two extra bits so unsigned 64-bit values stay positive
	localparam int EXT_W = XLEN + 2;
	// accumulator holds up to +-2x plus headroom
	localparam int ACC_W = EXT_W + 2;
	// accumulator, multiplier and the trailing booth bit
	localparam int PROD_W = ACC_W + EXT_W + 1;

	typedef logic [EXT_W-1:0] ext_t;
	typedef logic [ACC_W-1:0] acc_t;
	typedef logic [PROD_W-1:0] prod_t;
	typedef logic [5:0] step_cnt_t;

	// radix-4 steps per mode
	localparam step_cnt_t STEPS_D = 6'd33;
	localparam step_cnt_t STEPS_W = 6'd17;

	// bit 0 of the product sits here once all steps are done
	localparam int DWORD_LSB = EXT_W + 1 - 2 * 33;
	localparam int WORD_LSB = EXT_W + 1 - 2 * 17;

	// **************************************************
	// ops, commands and results
	// **************************************************

	typedef enum logic [2:0] {
		OP_MUL    = 3'd0,
		OP_MULH   = 3'd1,
		OP_MULHSU = 3'd2,
		OP_MULHU  = 3'd3,
		OP_MULW   = 3'd4
	} mul_op_t;

	typedef struct packed {
		mul_op_t   op;
		reg_addr_t rd;
		reg_addr_t rs1;
		reg_addr_t rs2;
	} mul_cmd_t;

	typedef struct packed {
		logic  word_mode;
		logic  sign_a;
		logic  sign_b;
		word_t multiplicand;
		word_t multiplier;
	} mul_req_t;

	typedef struct packed {
		word_t hi;
		word_t lo;
	} mul_res_t;

	typedef struct packed {
		reg_addr_t rd;
		word_t     data;
	} wb_t;

	// state machines
	typedef enum logic [1:0] {
		CTRL_IDLE = 2'd0,
		CTRL_RUN  = 2'd1,
		CTRL_WB   = 2'd2
	} ctrl_state_t;

	typedef enum logic [0:0] {
		BOOTH_IDLE = 1'b0,
		BOOTH_BUSY = 1'b1
	} booth_state_t;

endpackage

`default_nettype wire
